// ==== common/vec_pkg.sv ====
// Widths, Q16 fixed-point format, vector structs and helper functions for the vector engine
package vec_pkg;

    localparam int COORD_BITS = 32;
    localparam int Q_FRAC = 16;
    localparam int FIFO_DEPTH = 16;

    typedef logic signed [COORD_BITS-1:0] coord_t;
    // Full product before the Q16 shift
    typedef logic signed [2*COORD_BITS-1:0] wide_t;

    typedef struct packed {
        coord_t x_c;
        coord_t y_c;
        coord_t z_c;
    } vec3_t;

    // Operands of add, sub, dot and cross
    typedef struct packed {
        vec3_t a;
        vec3_t b;
    } vec_pair_t;

    typedef struct packed {
        vec3_t  v;
        coord_t k;
    } scale_in_t;

    // Q16 multiply, arithmetic shift, keep low word
    function automatic coord_t fx_mul(input coord_t a, input coord_t b);
        wide_t prod;
        prod = wide_t'(a) * wide_t'(b);
        return coord_t'(prod >>> Q_FRAC);
    endfunction

    // One cross-product lane: p - q in full width, then back to Q16
    function automatic coord_t cross_lane(input wide_t p, input wide_t q);
        wide_t diff;
        diff = p - q;
        return coord_t'(diff >>> Q_FRAC);
    endfunction

endpackage

// ==== hw/sync_fifo.sv ====
// Single-clock first-word-fall-through FIFO, buffers the results of one arithmetic unit
`timescale 1ns/100ps

module sync_fifo #(
    parameter int WIDTH = vec_pkg::COORD_BITS,
    parameter int DEPTH = vec_pkg::FIFO_DEPTH
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    output logic             full,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty
);

    localparam int ADDR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [ADDR_BITS-1:0] wr_ptr;
    logic [ADDR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0]  count;
    logic                 do_wr;
    logic                 do_rd;

    // Wrap explicitly so depths other than powers of two work
    function automatic logic [ADDR_BITS-1:0] next_ptr(input logic [ADDR_BITS-1:0] ptr);
        if (ptr == ADDR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == CNT_BITS'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head entry is always on the output
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_write_when_full: assert property (@(posedge clock) disable iff (reset)
        !(wr_en && full));

    a_count_bounded: assert property (@(posedge clock) disable iff (reset)
        count <= CNT_BITS'(DEPTH));

endmodule

// ==== vec_units/issue_ctrl.sv ====
// Read-then-write sequencer that pops one operand set and pushes one result per item
`timescale 1ns/100ps

module issue_ctrl (
    input  logic clock,
    input  logic reset,
    input  logic in_empty,
    output logic in_rd_en,
    input  logic full,
    output logic out_wr_en
);

    typedef enum logic {IDLE, WRITE} issue_state_e;

    issue_state_e state;
    issue_state_e next_state;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        in_rd_en = 1'b0;
        out_wr_en = 1'b0;
        case (state)
            IDLE: begin
                if (!in_empty) begin
                    in_rd_en = 1'b1;
                    next_state = WRITE;
                end
            end
            WRITE: begin
                // Hold the result until the FIFO has room
                if (!full) begin
                    out_wr_en = 1'b1;
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    a_strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(in_rd_en && out_wr_en));

    a_push_only_with_room: assert property (@(posedge clock) disable iff (reset)
        $rose(out_wr_en) |-> !full);

endmodule

// ==== vec_units/vec_addsub_unit.sv ====
// Element-wise add or subtract unit with result register and output FIFO
`timescale 1ns/100ps

module vec_addsub_unit #(
    parameter bit SUBTRACT = 1'b0
) (
    input  logic               clock,
    input  logic               reset,
    input  vec_pkg::vec_pair_t operands,
    input  logic               in_empty,
    output logic               in_rd_en,
    output vec_pkg::vec3_t     out,
    output logic               out_empty,
    input  logic               out_rd_en
);
    import vec_pkg::*;

    vec3_t result_c;
    vec3_t result_q;
    logic  fifo_full;
    logic  out_wr_en;

    issue_ctrl u_issue_ctrl (
        .clock     (clock),
        .reset     (reset),
        .in_empty  (in_empty),
        .in_rd_en  (in_rd_en),
        .full      (fifo_full),
        .out_wr_en (out_wr_en)
    );

    // Plain 32-bit wraparound per lane
    always_comb begin
        if (SUBTRACT) begin
            result_c.x_c = operands.a.x_c - operands.b.x_c;
            result_c.y_c = operands.a.y_c - operands.b.y_c;
            result_c.z_c = operands.a.z_c - operands.b.z_c;
        end else begin
            result_c.x_c = operands.a.x_c + operands.b.x_c;
            result_c.y_c = operands.a.y_c + operands.b.y_c;
            result_c.z_c = operands.a.z_c + operands.b.z_c;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_q <= '0;
        end else if (in_rd_en) begin
            result_q <= result_c;
        end
    end

    sync_fifo #(
        .WIDTH ($bits(vec3_t)),
        .DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (result_q),
        .full  (fifo_full),
        .rd_en (out_rd_en),
        .dout  (out),
        .empty (out_empty)
    );

endmodule

// ==== vec_units/vec_scale_unit.sv ====
// Q16 vector-by-scalar unit with result register and output FIFO
`timescale 1ns/100ps

module vec_scale_unit (
    input  logic               clock,
    input  logic               reset,
    input  vec_pkg::scale_in_t operands,
    input  logic               in_empty,
    output logic               in_rd_en,
    output vec_pkg::vec3_t     out,
    output logic               out_empty,
    input  logic               out_rd_en
);
    import vec_pkg::*;

    vec3_t result_c;
    vec3_t result_q;
    logic  fifo_full;
    logic  out_wr_en;

    issue_ctrl u_issue_ctrl (
        .clock     (clock),
        .reset     (reset),
        .in_empty  (in_empty),
        .in_rd_en  (in_rd_en),
        .full      (fifo_full),
        .out_wr_en (out_wr_en)
    );

    always_comb begin
        result_c.x_c = fx_mul(operands.v.x_c, operands.k);
        result_c.y_c = fx_mul(operands.v.y_c, operands.k);
        result_c.z_c = fx_mul(operands.v.z_c, operands.k);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_q <= '0;
        end else if (in_rd_en) begin
            result_q <= result_c;
        end
    end

    sync_fifo #(
        .WIDTH ($bits(vec3_t)),
        .DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (result_q),
        .full  (fifo_full),
        .rd_en (out_rd_en),
        .dout  (out),
        .empty (out_empty)
    );

endmodule

// ==== vec_units/vec_dot_unit.sv ====
// Q16 dot product unit with scalar result register and output FIFO
`timescale 1ns/100ps

module vec_dot_unit (
    input  logic               clock,
    input  logic               reset,
    input  vec_pkg::vec_pair_t operands,
    input  logic               in_empty,
    output logic               in_rd_en,
    output vec_pkg::coord_t    out,
    output logic               out_empty,
    input  logic               out_rd_en
);
    import vec_pkg::*;

    coord_t prod_x;
    coord_t prod_y;
    coord_t prod_z;
    coord_t result_c;
    coord_t result_q;
    logic   fifo_full;
    logic   out_wr_en;

    issue_ctrl u_issue_ctrl (
        .clock     (clock),
        .reset     (reset),
        .in_empty  (in_empty),
        .in_rd_en  (in_rd_en),
        .full      (fifo_full),
        .out_wr_en (out_wr_en)
    );

    // Lane products are already back in Q16, the sum wraps at 32 bits
    always_comb begin
        prod_x = fx_mul(operands.a.x_c, operands.b.x_c);
        prod_y = fx_mul(operands.a.y_c, operands.b.y_c);
        prod_z = fx_mul(operands.a.z_c, operands.b.z_c);
        result_c = prod_x + prod_y + prod_z;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_q <= '0;
        end else if (in_rd_en) begin
            result_q <= result_c;
        end
    end

    sync_fifo #(
        .WIDTH (COORD_BITS),
        .DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (result_q),
        .full  (fifo_full),
        .rd_en (out_rd_en),
        .dout  (out),
        .empty (out_empty)
    );

endmodule

// ==== vec_units/vec_cross_unit.sv ====
// Q16 cross product unit with result register and output FIFO
`timescale 1ns/100ps

module vec_cross_unit (
    input  logic               clock,
    input  logic               reset,
    input  vec_pkg::vec_pair_t operands,
    input  logic               in_empty,
    output logic               in_rd_en,
    output vec_pkg::vec3_t     out,
    output logic               out_empty,
    input  logic               out_rd_en
);
    import vec_pkg::*;

    vec_pair_t op;
    vec3_t     result_c;
    vec3_t     result_q;
    logic      fifo_full;
    logic      out_wr_en;

    issue_ctrl u_issue_ctrl (
        .clock     (clock),
        .reset     (reset),
        .in_empty  (in_empty),
        .in_rd_en  (in_rd_en),
        .full      (fifo_full),
        .out_wr_en (out_wr_en)
    );

    assign op = operands;

    // Products kept at full width, the shift happens after the difference
    always_comb begin
        result_c.x_c = cross_lane(wide_t'(op.a.y_c) * wide_t'(op.b.z_c),
                                  wide_t'(op.a.z_c) * wide_t'(op.b.y_c));
        result_c.y_c = cross_lane(wide_t'(op.a.z_c) * wide_t'(op.b.x_c),
                                  wide_t'(op.a.x_c) * wide_t'(op.b.z_c));
        result_c.z_c = cross_lane(wide_t'(op.a.x_c) * wide_t'(op.b.y_c),
                                  wide_t'(op.a.y_c) * wide_t'(op.b.x_c));
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            result_q <= '0;
        end else if (in_rd_en) begin
            result_q <= result_c;
        end
    end

    sync_fifo #(
        .WIDTH ($bits(vec3_t)),
        .DEPTH (FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (result_q),
        .full  (fifo_full),
        .rd_en (out_rd_en),
        .dout  (out),
        .empty (out_empty)
    );

endmodule

// ==== hw/vector_engine.sv ====
// Top level of the vector engine, five independent units each with its own input and output stream
`timescale 1ns/100ps

module vector_engine (
    input  logic               clock,
    input  logic               reset,

    input  vec_pkg::vec_pair_t add_operands,
    input  logic               add_in_empty,
    output logic               add_in_rd_en,
    output vec_pkg::vec3_t     add_out,
    output logic               add_out_empty,
    input  logic               add_out_rd_en,

    input  vec_pkg::vec_pair_t sub_operands,
    input  logic               sub_in_empty,
    output logic               sub_in_rd_en,
    output vec_pkg::vec3_t     sub_out,
    output logic               sub_out_empty,
    input  logic               sub_out_rd_en,

    input  vec_pkg::scale_in_t scale_operands,
    input  logic               scale_in_empty,
    output logic               scale_in_rd_en,
    output vec_pkg::vec3_t     scale_out,
    output logic               scale_out_empty,
    input  logic               scale_out_rd_en,

    input  vec_pkg::vec_pair_t dot_operands,
    input  logic               dot_in_empty,
    output logic               dot_in_rd_en,
    output vec_pkg::coord_t    dot_out,
    output logic               dot_out_empty,
    input  logic               dot_out_rd_en,

    input  vec_pkg::vec_pair_t cross_operands,
    input  logic               cross_in_empty,
    output logic               cross_in_rd_en,
    output vec_pkg::vec3_t     cross_out,
    output logic               cross_out_empty,
    input  logic               cross_out_rd_en
);

    vec_addsub_unit #(
        .SUBTRACT (1'b0)
    ) u_add (
        .clock     (clock),
        .reset     (reset),
        .operands  (add_operands),
        .in_empty  (add_in_empty),
        .in_rd_en  (add_in_rd_en),
        .out       (add_out),
        .out_empty (add_out_empty),
        .out_rd_en (add_out_rd_en)
    );

    // a minus b
    vec_addsub_unit #(
        .SUBTRACT (1'b1)
    ) u_sub (
        .clock     (clock),
        .reset     (reset),
        .operands  (sub_operands),
        .in_empty  (sub_in_empty),
        .in_rd_en  (sub_in_rd_en),
        .out       (sub_out),
        .out_empty (sub_out_empty),
        .out_rd_en (sub_out_rd_en)
    );

    vec_scale_unit u_scale (
        .clock     (clock),
        .reset     (reset),
        .operands  (scale_operands),
        .in_empty  (scale_in_empty),
        .in_rd_en  (scale_in_rd_en),
        .out       (scale_out),
        .out_empty (scale_out_empty),
        .out_rd_en (scale_out_rd_en)
    );

    vec_dot_unit u_dot (
        .clock     (clock),
        .reset     (reset),
        .operands  (dot_operands),
        .in_empty  (dot_in_empty),
        .in_rd_en  (dot_in_rd_en),
        .out       (dot_out),
        .out_empty (dot_out_empty),
        .out_rd_en (dot_out_rd_en)
    );

    vec_cross_unit u_cross (
        .clock     (clock),
        .reset     (reset),
        .operands  (cross_operands),
        .in_empty  (cross_in_empty),
        .in_rd_en  (cross_in_rd_en),
        .out       (cross_out),
        .out_empty (cross_out_empty),
        .out_rd_en (cross_out_rd_en)
    );

endmodule

// ==== verif/tb_vector_engine.sv ====
// Testbench for the vector engine: LCG stimulus on all five streams, expected-result queues, assertions
`timescale 1ns/100ps

module tb_vector_engine;
    import vec_pkg::*;

    localparam int N_UNITS = 5;
    localparam int ADD = 0;
    localparam int SUB = 1;
    localparam int SCALE = 2;
    localparam int DOT = 3;
    localparam int CROSS = 4;
    localparam int ITEMS = 40;
    localparam int WAIT_LIMIT = 2000;

    logic      clock;
    logic      reset;
    vec_pair_t add_ops;
    vec_pair_t sub_ops;
    scale_in_t scale_ops;
    vec_pair_t dot_ops;
    vec_pair_t cross_ops;
    vec3_t     add_out;
    vec3_t     sub_out;
    vec3_t     scale_out;
    coord_t    dot_out;
    vec3_t     cross_out;
    logic      in_empty [N_UNITS];
    logic      in_rd_en [N_UNITS];
    logic      out_empty [N_UNITS];
    logic      out_rd_en [N_UNITS];

    string     unit_name [N_UNITS] = '{"add", "sub", "scale", "dot", "cross"};
    int        to_send [N_UNITS];
    int        sent [N_UNITS];
    bit        taken [N_UNITS];
    bit        hold_cross;
    logic [31:0] lcg_state;

    // Expected results in issue order, head copies feed the assertions
    vec3_t     add_q [$];
    vec3_t     sub_q [$];
    vec3_t     scale_q [$];
    coord_t    dot_q [$];
    vec3_t     cross_q [$];
    vec3_t     add_head;
    vec3_t     sub_head;
    vec3_t     scale_head;
    coord_t    dot_head;
    vec3_t     cross_head;

    vector_engine DUT (
        .clock           (clock),
        .reset           (reset),
        .add_operands    (add_ops),
        .add_in_empty    (in_empty[ADD]),
        .add_in_rd_en    (in_rd_en[ADD]),
        .add_out         (add_out),
        .add_out_empty   (out_empty[ADD]),
        .add_out_rd_en   (out_rd_en[ADD]),
        .sub_operands    (sub_ops),
        .sub_in_empty    (in_empty[SUB]),
        .sub_in_rd_en    (in_rd_en[SUB]),
        .sub_out         (sub_out),
        .sub_out_empty   (out_empty[SUB]),
        .sub_out_rd_en   (out_rd_en[SUB]),
        .scale_operands  (scale_ops),
        .scale_in_empty  (in_empty[SCALE]),
        .scale_in_rd_en  (in_rd_en[SCALE]),
        .scale_out       (scale_out),
        .scale_out_empty (out_empty[SCALE]),
        .scale_out_rd_en (out_rd_en[SCALE]),
        .dot_operands    (dot_ops),
        .dot_in_empty    (in_empty[DOT]),
        .dot_in_rd_en    (in_rd_en[DOT]),
        .dot_out         (dot_out),
        .dot_out_empty   (out_empty[DOT]),
        .dot_out_rd_en   (out_rd_en[DOT]),
        .cross_operands  (cross_ops),
        .cross_in_empty  (in_empty[CROSS]),
        .cross_in_rd_en  (in_rd_en[CROSS]),
        .cross_out       (cross_out),
        .cross_out_empty (out_empty[CROSS]),
        .cross_out_rd_en (out_rd_en[CROSS])
    );

    always #4 clock = ~clock;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic report_mismatch(input string sig, input logic [95:0] expected,
                                   input logic [95:0] actual);
        stop_with_failure($sformatf("FAILED time=%0t signal=%s expected=%h actual=%h",
                                    $time, sig, expected, actual));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic vec3_t make_vec(input coord_t x, input coord_t y, input coord_t z);
        vec3_t v;
        v.x_c = x;
        v.y_c = y;
        v.z_c = z;
        return v;
    endfunction

    function automatic vec3_t rand_vec();
        return make_vec(lcg_next(), lcg_next(), lcg_next());
    endfunction

    // Q16 product: full 64-bit product, arithmetic shift, low word
    function automatic coord_t q16_mul(input coord_t a, input coord_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return coord_t'(p >>> Q_FRAC);
    endfunction

    function automatic coord_t cross_term(input coord_t a1, input coord_t b1,
                                          input coord_t a2, input coord_t b2);
        longint d;
        d = longint'(a1) * longint'(b1) - longint'(a2) * longint'(b2);
        return coord_t'(d >>> Q_FRAC);
    endfunction

    function automatic vec3_t addsub_ref(input vec_pair_t p, input bit sub);
        if (sub) begin
            return make_vec(p.a.x_c - p.b.x_c, p.a.y_c - p.b.y_c, p.a.z_c - p.b.z_c);
        end
        return make_vec(p.a.x_c + p.b.x_c, p.a.y_c + p.b.y_c, p.a.z_c + p.b.z_c);
    endfunction

    function automatic vec3_t scale_ref(input scale_in_t s);
        return make_vec(q16_mul(s.v.x_c, s.k), q16_mul(s.v.y_c, s.k), q16_mul(s.v.z_c, s.k));
    endfunction

    function automatic coord_t dot_ref(input vec_pair_t p);
        return q16_mul(p.a.x_c, p.b.x_c) + q16_mul(p.a.y_c, p.b.y_c)
               + q16_mul(p.a.z_c, p.b.z_c);
    endfunction

    function automatic vec3_t cross_ref(input vec_pair_t p);
        return make_vec(cross_term(p.a.y_c, p.b.z_c, p.a.z_c, p.b.y_c),
                        cross_term(p.a.z_c, p.b.x_c, p.a.x_c, p.b.z_c),
                        cross_term(p.a.x_c, p.b.y_c, p.a.y_c, p.b.x_c));
    endfunction

    function automatic int pending_results(input int u);
        case (u)
            ADD: return add_q.size();
            SUB: return sub_q.size();
            SCALE: return scale_q.size();
            DOT: return dot_q.size();
            default: return cross_q.size();
        endcase
    endfunction

    // First items are directed corner cases, the rest random
    task automatic load_operands(input int u, input int seq);
        case (u)
            ADD: begin
                add_ops.a = (seq == 0) ? make_vec(32'h7fff_ffff, 32'h8000_0000, -1) : rand_vec();
                add_ops.b = (seq == 0) ? make_vec(1, -1, 1) : rand_vec();
            end
            SUB: begin
                sub_ops.a = (seq == 0) ? make_vec(32'h8000_0000, 0, 5) : rand_vec();
                sub_ops.b = (seq == 0) ? make_vec(1, 32'h7fff_ffff, -7) : rand_vec();
            end
            SCALE: begin
                scale_ops.v = (seq == 0) ? make_vec(32'hfffe_8000, 32'h0002_4000, -1)
                                         : rand_vec();
                scale_ops.k = (seq == 0) ? 32'h0001_8000 : lcg_next();
            end
            DOT: begin
                dot_ops.a = (seq == 0) ? make_vec(32'hfffe_0000, 32'h0000_8000, 32'h0003_0000)
                                       : rand_vec();
                dot_ops.b = (seq == 0) ? make_vec(32'h0001_8000, 32'hfffc_0000, 32'h0000_4000)
                                       : rand_vec();
            end
            default: begin
                // x cross y gives z, then y cross z gives x
                if (seq == 0) begin
                    cross_ops.a = make_vec(32'h0001_0000, 0, 0);
                    cross_ops.b = make_vec(0, 32'h0001_0000, 0);
                end else if (seq == 1) begin
                    cross_ops.a = make_vec(0, 32'h0001_0000, 0);
                    cross_ops.b = make_vec(0, 0, 32'h0001_0000);
                end else begin
                    cross_ops.a = rand_vec();
                    cross_ops.b = rand_vec();
                end
            end
        endcase
    endtask

    task automatic wait_drained(input int u);
        int cycles;
        cycles = 0;
        while (sent[u] < to_send[u] || pending_results(u) != 0 || !out_empty[u]) begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure($sformatf("Timeout: the %s stream stalled before draining",
                                            unit_name[u]));
            end
        end
    endtask

    // Record pops and pushes as the DUT sees them on the rising edge
    always @(posedge clock) begin
        if (!reset) begin
            if (in_rd_en[ADD]) add_q.push_back(addsub_ref(add_ops, 1'b0));
            if (in_rd_en[SUB]) sub_q.push_back(addsub_ref(sub_ops, 1'b1));
            if (in_rd_en[SCALE]) scale_q.push_back(scale_ref(scale_ops));
            if (in_rd_en[DOT]) dot_q.push_back(dot_ref(dot_ops));
            if (in_rd_en[CROSS]) cross_q.push_back(cross_ref(cross_ops));
            for (int u = 0; u < N_UNITS; u++) begin
                if (in_rd_en[u]) begin
                    taken[u] = 1'b1;
                    sent[u]++;
                end
                if (out_rd_en[u] && !out_empty[u]) begin
                    if (pending_results(u) == 0) begin
                        stop_with_failure($sformatf("The %s unit delivered an unrequested result",
                                                    unit_name[u]));
                    end
                end
            end
            if (out_rd_en[ADD] && !out_empty[ADD]) void'(add_q.pop_front());
            if (out_rd_en[SUB] && !out_empty[SUB]) void'(sub_q.pop_front());
            if (out_rd_en[SCALE] && !out_empty[SCALE]) void'(scale_q.pop_front());
            if (out_rd_en[DOT] && !out_empty[DOT]) void'(dot_q.pop_front());
            if (out_rd_en[CROSS] && !out_empty[CROSS]) void'(cross_q.pop_front());
            add_head = (add_q.size() > 0) ? add_q[0] : '0;
            sub_head = (sub_q.size() > 0) ? sub_q[0] : '0;
            scale_head = (scale_q.size() > 0) ? scale_q[0] : '0;
            dot_head = (dot_q.size() > 0) ? dot_q[0] : '0;
            cross_head = (cross_q.size() > 0) ? cross_q[0] : '0;
        end
    end

    // Producer and consumer side of every stream
    always @(negedge clock) begin
        for (int u = 0; u < N_UNITS; u++) begin
            if (taken[u]) begin
                taken[u] = 1'b0;
                load_operands(u, sent[u]);
            end
            in_empty[u] = (sent[u] >= to_send[u]);
            if (u == CROSS && hold_cross) begin
                out_rd_en[u] = 1'b0;
            end else begin
                out_rd_en[u] = (lcg_next() >> 30) != 0;
            end
        end
    end

    a_add_result: assert property (@(posedge clock) disable iff (reset)
        (out_rd_en[ADD] && !out_empty[ADD]) |-> add_out == add_head)
        else report_mismatch("add_out", $sampled(add_head), $sampled(add_out));
    a_sub_result: assert property (@(posedge clock) disable iff (reset)
        (out_rd_en[SUB] && !out_empty[SUB]) |-> sub_out == sub_head)
        else report_mismatch("sub_out", $sampled(sub_head), $sampled(sub_out));
    a_scale_result: assert property (@(posedge clock) disable iff (reset)
        (out_rd_en[SCALE] && !out_empty[SCALE]) |-> scale_out == scale_head)
        else report_mismatch("scale_out", $sampled(scale_head), $sampled(scale_out));
    a_dot_result: assert property (@(posedge clock) disable iff (reset)
        (out_rd_en[DOT] && !out_empty[DOT]) |-> dot_out == dot_head)
        else report_mismatch("dot_out", $sampled(dot_head), $sampled(dot_out));
    a_cross_result: assert property (@(posedge clock) disable iff (reset)
        (out_rd_en[CROSS] && !out_empty[CROSS]) |-> cross_out == cross_head)
        else report_mismatch("cross_out", $sampled(cross_head), $sampled(cross_out));

    for (genvar g = 0; g < N_UNITS; g++) begin : g_stream_checks
        a_no_pop_while_empty: assert property (@(posedge clock) disable iff (reset)
            in_empty[g] |-> !in_rd_en[g])
            else stop_with_failure($sformatf("The %s unit popped an empty input stream",
                                             unit_name[g]));
        // Result appears two cycles after the pop when the FIFO was empty
        a_result_latency: assert property (@(posedge clock) disable iff (reset)
            (in_rd_en[g] && out_empty[g]) |-> ##1 out_empty[g] ##1 !out_empty[g])
            else stop_with_failure($sformatf("The %s unit missed its two-cycle result latency",
                                             unit_name[g]));
    end

    initial begin
        int start;
        int cycles;
        clock = 1'b0;
        reset = 1'b1;
        lcg_state = 32'd20;
        hold_cross = 1'b0;
        for (int u = 0; u < N_UNITS; u++) begin
            to_send[u] = 0;
            sent[u] = 0;
            taken[u] = 1'b0;
            in_empty[u] = 1'b1;
            out_rd_en[u] = 1'b0;
            load_operands(u, 0);
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Idle after reset: nothing buffered, nothing popped
        repeat (3) begin
            @(negedge clock);
            for (int u = 0; u < N_UNITS; u++) begin
                assert (out_empty[u] && !in_rd_en[u])
                    else stop_with_failure($sformatf("The %s unit is not idle after reset",
                                                     unit_name[u]));
            end
        end

        @(posedge clock);
        for (int u = 0; u < N_UNITS; u++) to_send[u] = ITEMS;
        for (int u = 0; u < N_UNITS; u++) wait_drained(u);

        // Cross back-pressure, consumer stopped
        @(posedge clock);
        start = sent[CROSS];
        hold_cross = 1'b1;
        to_send[CROSS] = to_send[CROSS] + 3 * FIFO_DEPTH;
        cycles = 0;
        while (sent[CROSS] < start + FIFO_DEPTH + 1) begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_with_failure("Timeout: the cross stream stalled before its FIFO filled");
            end
        end
        repeat (4 * FIFO_DEPTH) begin
            @(negedge clock);
            assert (!in_rd_en[CROSS])
                else stop_with_failure("The cross unit accepted operands with its FIFO full");
        end
        assert (sent[CROSS] == start + FIFO_DEPTH + 1)
            else stop_with_failure("The cross unit accepted the wrong number of operand sets");
        @(posedge clock);
        hold_cross = 1'b0;
        wait_drained(CROSS);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== all.f ====
common/vec_pkg.sv
hw/sync_fifo.sv
vec_units/issue_ctrl.sv
vec_units/vec_addsub_unit.sv
vec_units/vec_scale_unit.sv
vec_units/vec_dot_unit.sv
vec_units/vec_cross_unit.sv
hw/vector_engine.sv
verif/tb_vector_engine.sv

// ==== Bender.yml ====
package:
  name: vector_engine

sources:
  - common/vec_pkg.sv
  - hw/sync_fifo.sv
  - vec_units/issue_ctrl.sv
  - vec_units/vec_addsub_unit.sv
  - vec_units/vec_scale_unit.sv
  - vec_units/vec_dot_unit.sv
  - vec_units/vec_cross_unit.sv
  - hw/vector_engine.sv
  - target: test
    files:
      - verif/tb_vector_engine.sv
